//--- src/z1_pkg.sv
package z1_pkg;

    // Widths that carry a meaning on the board
    typedef logic [7:0] byte_t;     // One serial data byte
    typedef logic [7:0] addr_t;     // Internal register address
    typedef logic [5:0] led_t;      // Six board LEDs
    typedef logic [3:0] btn_t;      // One bit per push button
    typedef logic [1:0] sw_t;       // Slide switches

    // Command controller FSM
    typedef enum logic [2:0] {
        idle,                       // Waiting for a command byte
        get_addr,                   // Waiting for the address byte
        get_data,                   // Waiting for the write data byte
        bus,                        // Wishbone cycle in flight
        reply,                      // Reply byte ready, waiting for transmitter
        wait_tx                     // Reply on the line
    } ctrl_state_t;

    // Command and reply bytes, printable ASCII for terminal use
    localparam byte_t CMD_WRITE = 8'h57;    // W
    localparam byte_t CMD_READ  = 8'h52;    // R
    localparam byte_t RESP_OK   = 8'h4B;    // K
    localparam byte_t RESP_BAD  = 8'h3F;    // ?

    // Register map
    localparam addr_t ADDR_LEDS     = 8'h00;
    localparam addr_t ADDR_SCRATCH  = 8'h01;
    localparam addr_t ADDR_BTN0     = 8'h02;
    localparam addr_t ADDR_BTN1     = 8'h03;
    localparam addr_t ADDR_BTN2     = 8'h04;
    localparam addr_t ADDR_BTN3     = 8'h05;
    localparam addr_t ADDR_SWITCHES = 8'h06;

    // Board timing at about 66.7 MHz
    localparam int CLKS_PER_BIT     = 579;      // 115200 baud
    // Button sampled every 500 us
    localparam int B_SAMPLE_CNT_MAX = 33_333;
    localparam int B_PULSE_CNT_MAX  = 200;      // 100 ms of samples makes a press

endpackage

//--- src/button_parser.sv
`timescale 1ns/10ps

module button_parser #(
    parameter int WIDTH          = 4,
    parameter int SAMPLE_CNT_MAX = z1_pkg::B_SAMPLE_CNT_MAX,
    parameter int PULSE_CNT_MAX  = z1_pkg::B_PULSE_CNT_MAX
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    localparam int SW = $clog2(SAMPLE_CNT_MAX + 1);    // Sample counter width
    localparam int PW = $clog2(PULSE_CNT_MAX + 1);     // Per-button counter width

    logic [WIDTH-1:0] in_meta;
    logic [WIDTH-1:0] in_sync;
    logic [SW-1:0]    sample_cnt;
    logic             tick;
    logic [PW-1:0]    press_cnt [WIDTH];

    // Two-flop synchronizer, buttons are asynchronous to clk
    always_ff @(posedge clk) begin
        in_meta <= in;
        in_sync <= in_meta;
    end

    // Shared sample tick for all buttons
    assign tick = (sample_cnt == SW'(SAMPLE_CNT_MAX - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_cnt <= '0;
        end else if (tick) begin
            sample_cnt <= '0;
        end else begin
            sample_cnt <= sample_cnt + 1'b1;
        end
    end

    // Count consecutive high samples, saturate so a held button fires once
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WIDTH; i++) begin
                press_cnt[i] <= '0;
            end
        end else if (tick) begin
            for (int i = 0; i < WIDTH; i++) begin
                if (!in_sync[i]) begin
                    press_cnt[i] <= '0;                       // Bounce or release
                end else if (press_cnt[i] != PW'(PULSE_CNT_MAX)) begin
                    press_cnt[i] <= press_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Pulse on the tick where the count reaches PULSE_CNT_MAX
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            out[i] = tick && in_sync[i] && (press_cnt[i] == PW'(PULSE_CNT_MAX - 1));
        end
    end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BIT = z1_pkg::CLKS_PER_BIT
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          serial_in,
    output z1_pkg::byte_t data,
    output logic          valid
);
    import z1_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic          rx_meta;
    logic          rx_sync;
    logic          busy;
    logic [3:0]    bit_idx;     // 0 start, 1..8 data, 9 stop, 10 tail
    logic [CW-1:0] clk_cnt;
    logic [CW-1:0] cnt_last;
    logic          stop_ok;
    byte_t         shift;

    assign data = shift;

    // Half bit for start check and tail, full bit otherwise
    assign cnt_last = (bit_idx == 4'd0 || bit_idx == 4'd10) ?
                      CW'(CLKS_PER_BIT / 2 - 1) : CW'(CLKS_PER_BIT - 1);

    // Input synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= serial_in;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            valid   <= 1'b0;
            bit_idx <= '0;
            clk_cnt <= '0;
        end else begin
            valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin                 // Falling edge of start bit
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    clk_cnt <= '0;
                end
            end else if (clk_cnt != cnt_last) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt <= '0;
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0) begin
                    busy <= !rx_sync;               // Glitch, not a start bit
                end else if (bit_idx <= 4'd8) begin
                    shift <= {rx_sync, shift[7:1]}; // LSB first
                end else if (bit_idx == 4'd9) begin
                    stop_ok <= rx_sync;
                end else begin
                    busy  <= 1'b0;
                    valid <= stop_ok;               // Framing error drops the byte
                end
            end
        end
    end

endmodule

//--- src/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BIT = z1_pkg::CLKS_PER_BIT
) (
    input  logic          clk,
    input  logic          rst,
    input  z1_pkg::byte_t data,
    input  logic          start,
    output logic          serial_out,
    output logic          ready
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    logic [9:0]    frame;       // Stop, data, start; shifts out LSB first
    logic [3:0]    bits_left;
    logic [CW-1:0] clk_cnt;
    logic          busy;

    assign ready = !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            frame      <= '1;
            bits_left  <= '0;
            clk_cnt    <= '0;
            serial_out <= 1'b1;
        end else begin
            serial_out <= frame[0];             // Registered pin, no glitches
            if (!busy) begin
                if (start) begin
                    frame     <= {1'b1, data, 1'b0};
                    bits_left <= 4'd10;
                    clk_cnt   <= '0;
                    busy      <= 1'b1;
                end
            end else if (clk_cnt != CW'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= clk_cnt + 1'b1;
            end else begin
                clk_cnt   <= '0;
                frame     <= {1'b1, frame[9:1]};    // Backfill with idle level
                bits_left <= bits_left - 4'd1;
                busy      <= (bits_left != 4'd1);   // Done after the stop bit
            end
        end
    end

endmodule

//--- src/cmd_ctrl.sv
`timescale 1ns/10ps

module cmd_ctrl (
    input  logic          clk,
    input  logic          rst,
    input  z1_pkg::byte_t rx_data,
    input  logic          rx_valid,
    output z1_pkg::byte_t tx_data,
    output logic          tx_start,
    input  logic          tx_ready,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output z1_pkg::addr_t wb_adr,
    output z1_pkg::byte_t wb_dat_w,
    input  z1_pkg::byte_t wb_dat_r,
    input  logic          wb_ack
);
    import z1_pkg::*;

    ctrl_state_t state;
    logic        is_write;      // Current command is W

    assign wb_stb = wb_cyc;     // One transfer per cycle
    assign wb_we  = is_write;

    // Combinational so it lasts exactly the cycle state leaves reply
    assign tx_start = (state == reply) && tx_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            is_write <= 1'b0;
            wb_cyc   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (rx_valid) begin
                        case (rx_data)
                            CMD_WRITE: begin
                                is_write <= 1'b1;
                                state    <= get_addr;
                            end
                            CMD_READ: begin
                                is_write <= 1'b0;
                                state    <= get_addr;
                            end
                            default: begin
                                tx_data <= RESP_BAD;    // Unknown command
                                state   <= reply;
                            end
                        endcase
                    end
                end
                get_addr: begin
                    if (rx_valid) begin
                        wb_adr <= rx_data;
                        if (is_write) begin
                            state <= get_data;
                        end else begin
                            wb_cyc <= 1'b1;             // Read starts right away
                            state  <= bus;
                        end
                    end
                end
                get_data: begin
                    if (rx_valid) begin
                        wb_dat_w <= rx_data;
                        wb_cyc   <= 1'b1;
                        state    <= bus;
                    end
                end
                bus: begin
                    if (wb_ack) begin
                        wb_cyc  <= 1'b0;
                        tx_data <= is_write ? RESP_OK : wb_dat_r;
                        state   <= reply;
                    end
                end
                reply: begin
                    if (tx_ready) begin
                        state <= wait_tx;               // tx_start fires this cycle
                    end
                end
                wait_tx: begin
                    if (tx_ready) begin
                        state <= idle;                  // Reply frame finished
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- src/csr_regs.sv
`timescale 1ns/10ps

module csr_regs (
    input  logic          clk,
    input  logic          rst,
    input  logic          wb_cyc,
    input  logic          wb_stb,
    input  logic          wb_we,
    input  z1_pkg::addr_t wb_adr,
    input  z1_pkg::byte_t wb_dat_w,
    output z1_pkg::byte_t wb_dat_r,
    output logic          wb_ack,
    input  z1_pkg::btn_t  btn_pulse,
    input  z1_pkg::sw_t   switches,
    output z1_pkg::led_t  leds
);
    import z1_pkg::*;

    logic  bus_req;
    logic  wr_en;
    byte_t scratch;
    byte_t btn_cnt [$bits(btn_t)];
    sw_t   sw_meta;
    sw_t   sw_sync;
    byte_t rd_data;

    assign bus_req = wb_cyc && wb_stb && !wb_ack;   // New request, ack not yet given
    assign wr_en   = bus_req && wb_we;

    // Switch synchronizer
    always_ff @(posedge clk) begin
        sw_meta <= switches;
        sw_sync <= sw_meta;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack  <= 1'b0;
            leds    <= '0;
            scratch <= '0;
            for (int i = 0; i < $bits(btn_t); i++) begin
                btn_cnt[i] <= '0;
            end
        end else begin
            wb_ack <= bus_req;                      // Single-cycle ack
            if (wr_en && wb_adr == ADDR_LEDS) begin
                leds <= wb_dat_w[5:0];
            end
            if (wr_en && wb_adr == ADDR_SCRATCH) begin
                scratch <= wb_dat_w;
            end
            for (int i = 0; i < $bits(btn_t); i++) begin
                if (wr_en && wb_adr == ADDR_BTN0 + addr_t'(i)) begin
                    btn_cnt[i] <= '0;               // Clear wins over a press
                end else if (btn_pulse[i]) begin
                    btn_cnt[i] <= btn_cnt[i] + 8'd1; // Wraps at 255
                end
            end
        end
    end

    always_comb begin
        case (wb_adr)
            ADDR_LEDS:     rd_data = byte_t'(leds);
            ADDR_SCRATCH:  rd_data = scratch;
            ADDR_BTN0:     rd_data = btn_cnt[0];
            ADDR_BTN1:     rd_data = btn_cnt[1];
            ADDR_BTN2:     rd_data = btn_cnt[2];
            ADDR_BTN3:     rd_data = btn_cnt[3];
            ADDR_SWITCHES: rd_data = byte_t'(sw_sync);
            default:       rd_data = '0;            // Unmapped
        endcase
    end

    // Read data valid together with ack
    always_ff @(posedge clk) begin
        if (bus_req) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

//--- src/z1top.sv
`timescale 1ns/10ps

module z1top #(
    parameter int CLKS_PER_BIT     = z1_pkg::CLKS_PER_BIT,
    parameter int B_SAMPLE_CNT_MAX = z1_pkg::B_SAMPLE_CNT_MAX,
    parameter int B_PULSE_CNT_MAX  = z1_pkg::B_PULSE_CNT_MAX
) (
    input  logic         clk,
    input  logic         rst,
    input  z1_pkg::btn_t buttons,
    input  z1_pkg::sw_t  switches,
    output z1_pkg::led_t leds,
    input  logic         serial_rx,
    output logic         serial_tx
);
    import z1_pkg::*;

    btn_t  btn_pulse;
    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_start;
    logic  tx_ready;
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    byte_t wb_dat_w;
    byte_t wb_dat_r;
    logic  wb_ack;

    // Debounced press pulses, one per button
    button_parser #(
        .WIDTH          ($bits(btn_t)),
        .SAMPLE_CNT_MAX (B_SAMPLE_CNT_MAX),
        .PULSE_CNT_MAX  (B_PULSE_CNT_MAX)
    ) bp (
        .clk (clk),
        .rst (rst),
        .in  (buttons),
        .out (btn_pulse)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx (
        .clk       (clk),
        .rst       (rst),
        .serial_in (serial_rx),
        .data      (rx_data),
        .valid     (rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx (
        .clk        (clk),
        .rst        (rst),
        .data       (tx_data),
        .start      (tx_start),
        .serial_out (serial_tx),
        .ready      (tx_ready)
    );

    // Bus master
    cmd_ctrl ctrl (
        .clk      (clk),
        .rst      (rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_ready (tx_ready),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    csr_regs regs (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .btn_pulse (btn_pulse),
        .switches  (switches),
        .leds      (leds)
    );

endmodule

//--- testbench/z1top_props.sv
`timescale 1ns/10ps

module z1top_props (
    input logic clk,
    input logic rst,
    input logic serial_tx,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic rx_valid,
    input logic tx_start
);

    // Line idles high through reset, one cycle allowed for the output flop
    a_tx_idle_in_reset: assert property (@(posedge clk) (rst ##1 rst) |-> serial_tx)
        else $error("serial_tx low while rst is high");

    // Slave acks only a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack without wb_cyc and wb_stb");

    // Master ends the cycle right after ack, so ack cannot repeat
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> (!wb_cyc && !wb_stb && !wb_ack))
        else $error("bus cycle not closed after wb_ack");

    // Strobes between blocks are single-cycle
    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
        else $error("rx_valid high for two cycles");

    a_tx_start_pulse: assert property (@(posedge clk) disable iff (rst) tx_start |=> !tx_start)
        else $error("tx_start high for two cycles");

endmodule

bind z1top z1top_props props (
    .clk       (clk),
    .rst       (rst),
    .serial_tx (serial_tx),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .rx_valid  (rx_valid),
    .tx_start  (tx_start)
);

//--- testbench/tb_z1top.sv
`timescale 1ns/10ps

module tb_z1top;
    import z1_pkg::*;

    localparam int BIT    = 8;                      // Clocks per serial bit
    localparam int SAMPLE = 4;                      // Debounce sample interval
    localparam int PULSE  = 3;                      // High samples per press
    localparam int TMO    = 40 * BIT;               // Wait limit, 40 bit times
    localparam int HOLD   = (PULSE + 2) * SAMPLE;   // Button hold and release time

    logic  clk;
    logic  rst;
    btn_t  buttons;
    sw_t   switches;
    led_t  leds;
    logic  serial_rx;
    logic  serial_tx;

    // Reference model of the register block
    led_t  m_leds;
    byte_t m_scratch;
    byte_t m_cnt [4];
    sw_t   m_sw;

    int err_cnt = 0;
    int tmo_cnt = 0;

    z1top #(
        .CLKS_PER_BIT     (BIT),
        .B_SAMPLE_CNT_MAX (SAMPLE),
        .B_PULSE_CNT_MAX  (PULSE)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .switches  (switches),
        .leds      (leds),
        .serial_rx (serial_rx),
        .serial_tx (serial_tx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_leds(input string name, input led_t exp, input led_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Idle gap first, then start, data LSB first, stop
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        repeat (BIT) @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            serial_rx <= frame[i];
            repeat (BIT) @(posedge clk);
        end
    endtask

    // Sampled on the falling edge, mid-bit
    task automatic get_reply(input string name, output byte_t data, output bit got);
        int cnt;
        cnt = 0;
        got = 1'b0;
        data = '0;
        while (serial_tx !== 1'b0 && cnt < TMO) begin
            @(negedge clk);
            cnt++;
        end
        if (serial_tx !== 1'b0) begin
            tmo_cnt++;
            $display("%s: no reply frame on serial_tx within 40 bit times", name);
            return;
        end
        repeat (BIT / 2) @(negedge clk);            // Middle of start bit
        for (int i = 0; i < 8; i++) begin
            repeat (BIT) @(negedge clk);
            data[i] = serial_tx;
        end
        repeat (BIT) @(negedge clk);
        if (serial_tx !== 1'b1) begin
            err_cnt++;
            $display("%s: reply frame has a low stop bit", name);
        end
        repeat (BIT) @(negedge clk);                // Controller back in idle
        got = 1'b1;
    endtask

    task automatic expect_quiet();
        int cnt;
        bit low;
        cnt = 0;
        low = 1'b0;
        while (cnt < TMO && !low) begin
            @(negedge clk);
            low = (serial_tx !== 1'b1);
            cnt++;
        end
        if (low) begin
            err_cnt++;
            $display("serial_tx left idle although no command was sent");
        end
    endtask

    function automatic byte_t model_read(input addr_t addr);
        case (addr)
            ADDR_LEDS:     return byte_t'(m_leds);
            ADDR_SCRATCH:  return m_scratch;
            ADDR_BTN0:     return m_cnt[0];
            ADDR_BTN1:     return m_cnt[1];
            ADDR_BTN2:     return m_cnt[2];
            ADDR_BTN3:     return m_cnt[3];
            ADDR_SWITCHES: return byte_t'(m_sw);
            default:       return 8'h00;
        endcase
    endfunction

    task automatic do_write(input addr_t addr, input byte_t data, input string name);
        byte_t r;
        bit    got;
        send_byte(CMD_WRITE);
        send_byte(addr);
        send_byte(data);
        if (addr == ADDR_LEDS) m_leds = data[5:0];
        else if (addr == ADDR_SCRATCH) m_scratch = data;
        else if (addr >= ADDR_BTN0 && addr <= ADDR_BTN3) m_cnt[addr - ADDR_BTN0] = '0;
        get_reply(name, r, got);
        if (got) check_byte(name, RESP_OK, r);
    endtask

    task automatic do_read(input addr_t addr, input string name);
        byte_t r;
        bit    got;
        send_byte(CMD_READ);
        send_byte(addr);
        get_reply(name, r, got);
        if (got) check_byte(name, model_read(addr), r);
    endtask

    // One press, held long enough for the debouncer, then a full release
    task automatic press_button(input int idx);
        @(posedge clk);
        buttons <= btn_t'(1 << idx);
        repeat (HOLD) @(posedge clk);
        buttons <= '0;
        repeat (HOLD) @(posedge clk);
        m_cnt[idx]++;
    endtask

    initial begin
        byte_t r;
        byte_t c;
        bit    got;
        sw_t   s;
        addr_t a;
        int    k;
        void'($urandom(11657));
        rst       <= 1'b1;
        buttons   <= '0;
        switches  <= '0;
        serial_rx <= 1'b1;
        m_leds    = '0;
        m_scratch = '0;
        m_sw      = '0;
        for (k = 0; k < 4; k++) m_cnt[k] = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        check_leds("reset_leds", '0, leds);
        expect_quiet();

        repeat (12) begin                           // LED and scratch writes
            a = ($urandom & 1) ? ADDR_SCRATCH : ADDR_LEDS;
            do_write(a, byte_t'($urandom), "write");
            check_leds("write_leds", m_leds, leds);
        end

        for (k = 0; k < 10; k++) begin              // Whole map plus unmapped
            s = sw_t'($urandom);
            @(posedge clk);
            switches <= s;
            m_sw = s;
            a = (k < 7) ? addr_t'(k) : addr_t'($urandom_range(255, 7));
            do_read(a, "read");
        end

        repeat (8) begin                            // Unknown commands
            do c = byte_t'($urandom); while (c == CMD_WRITE || c == CMD_READ);
            send_byte(c);
            get_reply("bad_cmd", r, got);
            if (got) check_byte("bad_cmd", RESP_BAD, r);
            check_leds("bad_cmd_leds", m_leds, leds);
        end
        do_read(ADDR_SCRATCH, "bad_cmd_scratch");

        repeat (8) begin                            // Button presses
            k = $urandom_range(3, 0);
            press_button(k);
            do_read(ADDR_BTN0 + addr_t'(k), "btn_count");
        end
        for (k = 0; k < 4; k++) begin
            do_write(ADDR_BTN0 + addr_t'(k), byte_t'($urandom), "btn_clear");
            do_read(ADDR_BTN0 + addr_t'(k), "btn_cleared");
        end

        $display("Error counts: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sources.f
src/z1_pkg.sv
src/button_parser.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_ctrl.sv
src/csr_regs.sv
src/z1top.sv
testbench/z1top_props.sv
testbench/tb_z1top.sv
